//--- engine_csr_index.f
logic/csr_index_pkg.sv
logic/sync_fifo.sv
logic/response_router.sv
logic/csr_config_memory.sv
logic/csr_index_generator.sv
logic/engine_csr_index.sv
test/tb_engine_csr_index.sv

//--- Makefile
# Verilator lint and simulation for the CSR index engine

VERILATOR ?= verilator
TOP       ?= tb_engine_csr_index
RTL_TOP   ?= engine_csr_index
FILELIST  ?= engine_csr_index.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_engine_csr_index.sv
// ------------------------------
// CSR index engine testbench
// Memory model, random back-pressure and a packet scoreboard
// ------------------------------
`default_nettype none

module tb_engine_csr_index;

    import csr_index_pkg::*;

    localparam logic [ADDR_W-1:0] BASE_A = 32'h0004_0000;
    localparam int START_A        = 100;
    localparam int START_B        = 7;
    localparam int VERTEX_COUNT   = 16;
    // Two runs of VERTEX_COUNT vertices each
    localparam int TIMEOUT_CYCLES = 64 * (2 * VERTEX_COUNT) + 500;

    logic           ap_clk;
    logic           areset_csr_engine;
    logic           descriptor_valid_i;
    mem_response_t  response_memory_i = '0;
    logic           response_memory_valid_i = 1'b0;
    logic           response_memory_ready_o;
    mem_request_t   request_memory_o;
    logic           request_memory_valid_o;
    logic           request_memory_ready_i = 1'b0;
    engine_packet_t engine_packet_o;
    logic           engine_valid_o;
    logic           engine_ready_i = 1'b0;
    logic           done_o;

    logic [31:0]         lfsr_state = 32'hac16;
    mem_response_t       resp_queue[$];
    bit                  pending[int];
    bit                  sending = 1'b0;
    bit                  random_mode = 1'b0;
    int                  resp_delay = 0;
    int                  req_count = 0;
    int                  pkt_count = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  cycle_count = 0;
    logic [ADDR_W-1:0]   run_base = '0;
    logic [VERTEX_W-1:0] run_start = '0;
    int                  run_count = 0;

    engine_csr_index uut (.*);

    initial begin
        ap_clk = 1'b0;
        forever #20 ap_clk = ~ap_clk;
    end

    // Galois LFSR stepped once per bit
    function automatic logic take_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic int take_bits(input int count);
        int value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(take_bit());
        end
        return value;
    endfunction

    // Offset table contents as a fixed hash of the entry address
    function automatic logic [DATA_W-1:0] expected_offset(input logic [ADDR_W-1:0] address);
        return (address * 32'h9e37_79b1) ^ {address[15:0], address[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [ADDR_W-1:0] vertex_address(input logic [VERTEX_W-1:0] vertex);
        return run_base + ADDR_W'(vertex) * ADDR_W'(INDEX_BYTES);
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_request(input mem_request_t got, input mem_request_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] request_memory_o got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic check_packet(input engine_packet_t got, input engine_packet_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] engine_packet_o got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic check_done(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error: %s", what);
    endtask

    // Memory model with in-order answers and the ready drivers
    always @(posedge ap_clk) begin : memory_model
        mem_request_t  exp_req;
        mem_response_t answer;
        if (request_memory_valid_o && request_memory_ready_i) begin
            exp_req.tag       = run_start + VERTEX_W'(req_count);
            exp_req.address   = vertex_address(exp_req.tag);
            exp_req.module_id = ROUTE_GENERATOR;
            if (req_count >= run_count) begin
                report_error($sformatf("request for tag 0x%h beyond the vertex count",
                                       request_memory_o.tag));
            end else begin
                check_request(request_memory_o, exp_req);
            end
            req_count++;
            answer.module_id = request_memory_o.module_id;
            answer.opcode    = CFG_NONE;
            answer.tag       = request_memory_o.tag;
            answer.data      = expected_offset(request_memory_o.address);
            resp_queue.push_back(answer);
        end
        if (response_memory_valid_i && response_memory_ready_o) begin
            response_memory_valid_i <= 1'b0;
            sending = 1'b0;
            resp_delay = random_mode ? take_bits(2) : 0;
        end
        if (!sending && resp_queue.size() != 0) begin
            if (resp_delay == 0) begin
                response_memory_i       <= resp_queue.pop_front();
                response_memory_valid_i <= 1'b1;
                sending = 1'b1;
            end else begin
                resp_delay--;
            end
        end
        request_memory_ready_i <= random_mode ? take_bit() : 1'b1;
        engine_ready_i         <= random_mode ? take_bit() : 1'b1;
    end

    // Scoreboard for engine packets
    always @(posedge ap_clk) begin : packet_compare
        engine_packet_t exp_pkt;
        int             key;
        if (engine_valid_o && engine_ready_i) begin
            key = int'(engine_packet_o.vertex);
            if (!pending.exists(key)) begin
                report_error($sformatf("engine packet for vertex 0x%h is unexpected or repeated",
                                       engine_packet_o.vertex));
            end else begin
                exp_pkt.vertex = engine_packet_o.vertex;
                exp_pkt.offset = expected_offset(vertex_address(engine_packet_o.vertex));
                check_packet(engine_packet_o, exp_pkt);
                pending.delete(key);
            end
            pkt_count++;
        end
    end

    initial begin : watchdog
        gen_state_e state;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        state = uut.u_generator.state_q;
        $display("Timeout after %0d cycles, generator in %s", cycle_count, state.name());
        $display("Simulation FAILED");
        $finish;
    end

    // ------------------------------
    // Sequencing
    // ------------------------------
    task automatic queue_config(input cfg_opcode_e opcode, input logic [DATA_W-1:0] value);
        mem_response_t word;
        word.module_id = ROUTE_CONFIG;
        word.opcode    = opcode;
        word.tag       = '0;
        word.data      = value;
        resp_queue.push_back(word);
    endtask

    task automatic prepare_run(input int start, input bit randomize);
        run_start   = VERTEX_W'(start);
        random_mode = randomize;
        req_count   = 0;
        pkt_count   = 0;
        for (int v = 0; v < run_count; v++) begin
            pending[start + v] = 1'b1;
        end
    endtask

    // Config words pass the response FIFO, router and store
    task automatic wait_channel_idle(input logic done_level);
        do begin
            @(negedge ap_clk);
            check_done("done_o", done_o, done_level);
        end while (resp_queue.size() != 0 || response_memory_valid_i);
        repeat (4) begin
            @(posedge ap_clk);
            check_done("done_o", done_o, done_level);
        end
    endtask

    task automatic run_to_done();
        @(posedge ap_clk);
        descriptor_valid_i <= 1'b1;
        @(posedge ap_clk);
        descriptor_valid_i <= 1'b0;
        @(posedge ap_clk);
        check_done("done_o", done_o, 1'b0);
        while (!done_o) begin
            @(posedge ap_clk);
        end
        if (pending.size() != 0 || pkt_count != run_count) begin
            report_error($sformatf("done rose after %0d of %0d engine packets",
                                   pkt_count, run_count));
        end
        if (req_count != run_count) begin
            report_error($sformatf("run issued %0d requests for %0d vertices",
                                   req_count, run_count));
        end
        repeat (8) begin
            @(posedge ap_clk);
            check_done("done_o", done_o, 1'b1);
        end
    endtask

    task automatic report_test(input int number, input string name, input int mark);
        $display("test %0d %s: %0d errors", number, name, errors - mark);
    endtask

    initial begin : main
        int mark;
        areset_csr_engine  <= 1'b1;
        descriptor_valid_i <= 1'b0;
        repeat (16) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;

        mark = errors;
        @(posedge ap_clk);
        check_done("request_memory_valid_o", request_memory_valid_o, 1'b0);
        check_done("engine_valid_o", engine_valid_o, 1'b0);
        check_done("done_o", done_o, 1'b0);
        check_done("response_memory_ready_o", response_memory_ready_o, 1'b1);
        descriptor_valid_i <= 1'b1;
        @(posedge ap_clk);
        descriptor_valid_i <= 1'b0;
        repeat (20) begin
            @(posedge ap_clk);
            check_done("request_memory_valid_o", request_memory_valid_o, 1'b0);
        end
        report_test(1, "reset state and unconfigured descriptor", mark);

        mark = errors;
        @(negedge ap_clk);
        run_base  = BASE_A;
        run_count = VERTEX_COUNT;
        prepare_run(START_A, 1'b0);
        queue_config(CFG_ARRAY_BASE, BASE_A);
        queue_config(CFG_VERTEX_START, DATA_W'(START_A));
        queue_config(CFG_VERTEX_COUNT, DATA_W'(VERTEX_COUNT));
        wait_channel_idle(1'b0);
        run_to_done();
        report_test(2, "full run with free-flowing outputs", mark);

        // Only the start vertex changes while base and count are kept
        mark = errors;
        @(negedge ap_clk);
        prepare_run(START_B, 1'b1);
        queue_config(CFG_VERTEX_START, DATA_W'(START_B));
        wait_channel_idle(1'b1);
        run_to_done();
        report_test(3, "new start vertex under random back-pressure", mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_engine_csr_index

`default_nettype wire

//--- logic/engine_csr_index.sv
// ------------------------------
// CSR index engine top level
// Queues, response routing, config store and generator
// ------------------------------
`default_nettype none

module engine_csr_index (
    input  wire logic                          ap_clk,
    input  wire logic                          areset_csr_engine,
    input  wire logic                          descriptor_valid_i,
    input  wire csr_index_pkg::mem_response_t  response_memory_i,
    input  wire logic                          response_memory_valid_i,
    output logic                               response_memory_ready_o,
    output csr_index_pkg::mem_request_t        request_memory_o,
    output logic                               request_memory_valid_o,
    input  wire logic                          request_memory_ready_i,
    output csr_index_pkg::engine_packet_t      engine_packet_o,
    output logic                               engine_valid_o,
    input  wire logic                          engine_ready_i,
    output logic                               done_o
);

    import csr_index_pkg::*;

    mem_response_t  resp_q_data;
    logic           resp_q_valid;
    logic           resp_q_ready;
    logic           resp_q_empty;
    mem_response_t  cfg_resp;
    logic           cfg_valid;
    mem_response_t  gen_resp;
    logic           gen_valid;
    logic           gen_ready;
    csr_config_t    cfg_rec;
    logic           cfg_ready;
    mem_request_t   req_data;
    logic           req_valid;
    logic           req_ready;
    logic           req_q_empty;
    engine_packet_t pkt_data;
    logic           pkt_valid;
    logic           pkt_ready;
    logic           pkt_q_empty;
    logic           run_done;

    // ------------------------------
    // Memory response path
    // ------------------------------
    sync_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH($bits(mem_response_t))) u_resp_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .wr_data_i(response_memory_i), .wr_valid_i(response_memory_valid_i),
        .wr_ready_o(response_memory_ready_o), .rd_data_o(resp_q_data),
        .rd_valid_o(resp_q_valid), .rd_ready_i(resp_q_ready), .empty_o(resp_q_empty)
    );

    response_router u_router (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .resp_i(resp_q_data), .resp_valid_i(resp_q_valid), .resp_ready_o(resp_q_ready),
        .cfg_resp_o(cfg_resp), .cfg_valid_o(cfg_valid),
        .gen_resp_o(gen_resp), .gen_valid_o(gen_valid), .gen_ready_i(gen_ready)
    );

    csr_config_memory u_config (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .cfg_resp_i(cfg_resp), .cfg_valid_i(cfg_valid),
        .config_o(cfg_rec), .config_ready_o(cfg_ready)
    );

    csr_index_generator u_generator (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .start_i(descriptor_valid_i), .config_i(cfg_rec), .config_ready_i(cfg_ready),
        .req_o(req_data), .req_valid_o(req_valid), .req_ready_i(req_ready),
        .resp_i(gen_resp), .resp_valid_i(gen_valid), .resp_ready_o(gen_ready),
        .pkt_o(pkt_data), .pkt_valid_o(pkt_valid), .pkt_ready_i(pkt_ready),
        .run_done_o(run_done)
    );

    // ------------------------------
    // Output queues
    // ------------------------------
    sync_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH($bits(mem_request_t))) u_req_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .wr_data_i(req_data), .wr_valid_i(req_valid), .wr_ready_o(req_ready),
        .rd_data_o(request_memory_o), .rd_valid_o(request_memory_valid_o),
        .rd_ready_i(request_memory_ready_i), .empty_o(req_q_empty)
    );

    sync_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH($bits(engine_packet_t))) u_pkt_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .wr_data_i(pkt_data), .wr_valid_i(pkt_valid), .wr_ready_o(pkt_ready),
        .rd_data_o(engine_packet_o), .rd_valid_o(engine_valid_o),
        .rd_ready_i(engine_ready_i), .empty_o(pkt_q_empty)
    );

    // Done holds from a drained finished run until the next accepted descriptor
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            done_o <= 1'b0;
        end else if (descriptor_valid_i && cfg_ready) begin
            done_o <= 1'b0;
        end else if (run_done && resp_q_empty && req_q_empty && pkt_q_empty) begin
            done_o <= 1'b1;
        end
    end

endmodule : engine_csr_index

`default_nettype wire

//--- logic/csr_index_generator.sv
// ------------------------------
// CSR index generator
// Issues offset reads per vertex and forms engine packets
// ------------------------------
`default_nettype none

module csr_index_generator (
    input  wire logic                          ap_clk,
    input  wire logic                          areset_csr_engine,
    input  wire logic                          start_i,
    input  wire csr_index_pkg::csr_config_t    config_i,
    input  wire logic                          config_ready_i,
    output csr_index_pkg::mem_request_t        req_o,
    output logic                               req_valid_o,
    input  wire logic                          req_ready_i,
    input  wire csr_index_pkg::mem_response_t  resp_i,
    input  wire logic                          resp_valid_i,
    output logic                               resp_ready_o,
    output csr_index_pkg::engine_packet_t      pkt_o,
    output logic                               pkt_valid_o,
    input  wire logic                          pkt_ready_i,
    output logic                               run_done_o
);

    import csr_index_pkg::*;

    gen_state_e          state_q;
    logic [ADDR_W-1:0]   base_q;
    logic [VERTEX_W-1:0] vertex_q;
    logic [VERTEX_W-1:0] remaining_q;
    logic [VERTEX_W-1:0] outstanding_q;
    logic                start_ok;
    logic                req_fire;
    logic                resp_fire;

    // A new run may start from idle or after a finished run
    assign start_ok  = start_i && config_ready_i &&
                       ((state_q == GEN_IDLE) || (state_q == GEN_DONE));
    assign req_fire  = req_valid_o & req_ready_i;
    assign resp_fire = resp_valid_i & resp_ready_o;

    // ------------------------------
    // Request issue
    // ------------------------------
    assign req_valid_o     = (state_q == GEN_ISSUE) && (remaining_q != '0);
    assign req_o.address   = base_q + ADDR_W'(vertex_q) * ADDR_W'(INDEX_BYTES);
    assign req_o.tag       = vertex_q;
    assign req_o.module_id = ROUTE_GENERATOR;

    // ------------------------------
    // Response to packet
    // ------------------------------
    assign resp_ready_o = pkt_ready_i;
    assign pkt_valid_o  = resp_valid_i;
    assign pkt_o.vertex = resp_i.tag;
    assign pkt_o.offset = resp_i.data;

    assign run_done_o = (state_q == GEN_DONE);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state_q <= GEN_IDLE;
        end else begin
            case (state_q)
                GEN_IDLE, GEN_DONE: begin
                    if (start_ok) begin
                        state_q <= GEN_ISSUE;
                    end
                end
                GEN_ISSUE: begin
                    if (remaining_q == '0) begin
                        state_q <= GEN_DRAIN;
                    end
                end
                // Wait for every issued read to come back and be forwarded
                GEN_DRAIN: begin
                    if (outstanding_q == '0) begin
                        state_q <= GEN_DONE;
                    end
                end
                default: state_q <= GEN_IDLE;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            remaining_q   <= '0;
            outstanding_q <= '0;
        end else begin
            if (start_ok) begin
                remaining_q <= config_i.vertex_count;
            end else if (req_fire) begin
                remaining_q <= remaining_q - 1'b1;
            end
            if (req_fire && !resp_fire) begin
                outstanding_q <= outstanding_q + 1'b1;
            end else if (resp_fire && !req_fire) begin
                outstanding_q <= outstanding_q - 1'b1;
            end
        end
    end

    // Run base and current vertex, latched at start
    always_ff @(posedge ap_clk) begin
        if (start_ok) begin
            base_q   <= config_i.array_base;
            vertex_q <= config_i.vertex_start;
        end else if (req_fire) begin
            vertex_q <= vertex_q + 1'b1;
        end
    end

endmodule : csr_index_generator

`default_nettype wire

//--- logic/csr_config_memory.sv
// ------------------------------
// CSR configuration store
// Decodes config words and reports when all fields are set
// ------------------------------
`default_nettype none

module csr_config_memory (
    input  wire logic                          ap_clk,
    input  wire logic                          areset_csr_engine,
    input  wire csr_index_pkg::mem_response_t  cfg_resp_i,
    input  wire logic                          cfg_valid_i,
    output csr_index_pkg::csr_config_t         config_o,
    output logic                               config_ready_o
);

    import csr_index_pkg::*;

    csr_config_t cfg_q;
    // Bit 0 base, bit 1 start, bit 2 count
    logic [2:0]  seen_q;

    assign config_o       = cfg_q;
    assign config_ready_o = &seen_q;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            seen_q <= '0;
        end else if (cfg_valid_i) begin
            case (cfg_resp_i.opcode)
                CFG_ARRAY_BASE:   seen_q[0] <= 1'b1;
                CFG_VERTEX_START: seen_q[1] <= 1'b1;
                CFG_VERTEX_COUNT: seen_q[2] <= 1'b1;
                default:          seen_q    <= seen_q;
            endcase
        end
    end

    // Field values, a later word simply overwrites its field
    always_ff @(posedge ap_clk) begin
        if (cfg_valid_i) begin
            case (cfg_resp_i.opcode)
                CFG_ARRAY_BASE:   cfg_q.array_base   <= cfg_resp_i.data[ADDR_W-1:0];
                CFG_VERTEX_START: cfg_q.vertex_start <= cfg_resp_i.data[VERTEX_W-1:0];
                CFG_VERTEX_COUNT: cfg_q.vertex_count <= cfg_resp_i.data[VERTEX_W-1:0];
                default:          cfg_q              <= cfg_q;
            endcase
        end
    end

endmodule : csr_config_memory

`default_nettype wire

//--- logic/response_router.sv
// ------------------------------
// Memory response router
// Splits responses between config and generator by module id
// ------------------------------
`default_nettype none

module response_router (
    input  wire logic                          ap_clk,
    input  wire logic                          areset_csr_engine,
    input  wire csr_index_pkg::mem_response_t  resp_i,
    input  wire logic                          resp_valid_i,
    output logic                               resp_ready_o,
    output csr_index_pkg::mem_response_t       cfg_resp_o,
    output logic                               cfg_valid_o,
    output csr_index_pkg::mem_response_t       gen_resp_o,
    output logic                               gen_valid_o,
    input  wire logic                          gen_ready_i
);

    import csr_index_pkg::*;

    mem_response_t hold_q;
    logic          hold_valid_q;
    logic          leave;

    // One beat in flight, no new accept until it has left
    assign resp_ready_o = ~hold_valid_q;
    assign cfg_valid_o  = hold_valid_q && (hold_q.module_id == ROUTE_CONFIG);
    assign gen_valid_o  = hold_valid_q && (hold_q.module_id == ROUTE_GENERATOR);
    assign cfg_resp_o   = hold_q;
    assign gen_resp_o   = hold_q;

    // Config side never stalls
    assign leave = cfg_valid_o | (gen_valid_o & gen_ready_i);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            hold_valid_q <= 1'b0;
        end else if (resp_valid_i && resp_ready_o) begin
            hold_valid_q <= 1'b1;
        end else if (leave) begin
            hold_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (resp_valid_i && resp_ready_o) begin
            hold_q <= resp_i;
        end
    end

endmodule : response_router

`default_nettype wire

//--- logic/sync_fifo.sv
// ------------------------------
// Synchronous show-ahead FIFO
// Circular buffer with valid/ready on both sides
// ------------------------------
`default_nettype none

module sync_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 32
) (
    input  wire logic             ap_clk,
    input  wire logic             areset_csr_engine,
    input  wire logic [WIDTH-1:0] wr_data_i,
    input  wire logic             wr_valid_i,
    output logic                  wr_ready_o,
    output logic      [WIDTH-1:0] rd_data_o,
    output logic                  rd_valid_o,
    input  wire logic             rd_ready_i,
    output logic                  empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign push       = wr_valid_i & wr_ready_o;
    assign pop        = rd_valid_o & rd_ready_i;
    assign wr_ready_o = (count_q != CNT_W'(DEPTH));
    assign rd_valid_o = (count_q != '0);
    assign empty_o    = (count_q == '0);
    // Head entry is always presented
    assign rd_data_o  = mem[rd_ptr_q];

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

endmodule : sync_fifo

`default_nettype wire

//--- logic/csr_index_pkg.sv
// ------------------------------
// CSR index engine shared types
// Widths, encodings and the records moved between blocks
// ------------------------------
`default_nettype none

package csr_index_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int VERTEX_W    = 24;
    localparam int INDEX_BYTES = 4;
    localparam int FIFO_DEPTH  = 8;

    // Destination of a memory response
    typedef enum logic {
        ROUTE_CONFIG    = 1'b0,
        ROUTE_GENERATOR = 1'b1
    } module_id_e;

    typedef enum logic [1:0] {
        CFG_NONE         = 2'd0,
        CFG_ARRAY_BASE   = 2'd1,
        CFG_VERTEX_START = 2'd2,
        CFG_VERTEX_COUNT = 2'd3
    } cfg_opcode_e;

    typedef enum logic [1:0] {
        GEN_IDLE  = 2'd0,
        GEN_ISSUE = 2'd1,
        GEN_DRAIN = 2'd2,
        GEN_DONE  = 2'd3
    } gen_state_e;

    // ------------------------------
    // Bus records
    // ------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0]   address;
        logic [VERTEX_W-1:0] tag;
        module_id_e          module_id;
    } mem_request_t;

    typedef struct packed {
        module_id_e          module_id;
        cfg_opcode_e         opcode;
        logic [VERTEX_W-1:0] tag;
        logic [DATA_W-1:0]   data;
    } mem_response_t;

    typedef struct packed {
        logic [VERTEX_W-1:0] vertex;
        logic [DATA_W-1:0]   offset;
    } engine_packet_t;

    // Held run configuration
    typedef struct packed {
        logic [ADDR_W-1:0]   array_base;
        logic [VERTEX_W-1:0] vertex_start;
        logic [VERTEX_W-1:0] vertex_count;
    } csr_config_t;

endpackage : csr_index_pkg

`default_nettype wire
